// ==== flist.f ====
rtl/mips_isa_pkg.sv
rtl/avalon_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/pc_unit.sv
rtl/cpu_control.sv
rtl/avalon_ram.sv
rtl/cpu_system.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpu_tb
FILELIST = flist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	-./obj_dir/$(TOP)_sim > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test OK" $(LOG) && ! grep -q "Test FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import mips_isa_pkg::*;

    logic clk = 1'b0;
    logic rst;
    logic inst_input;
    logic [7:0] inst_addr;
    logic [31:0] instruction;
    logic active;
    logic [31:0] register_v0;

    logic [31:0] prog [$];         // Program words, placed from byte address 4.
    logic [31:0] expected_q [$];
    logic [31:0] rng_state = 32'd64360;
    logic was_active = 1'b0;
    int halts_seen = 0;
    int checks = 0;
    int errors = 0;

    cpu_system uut (
        .clk, .rst, .inst_input, .inst_addr, .instruction, .active, .register_v0
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic emit_i(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                          input logic [15:0] imm16);
        prog.push_back({op, rs, rt, imm16});
    endtask

    task automatic emit_r(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
                          input logic [5:0] fn);
        prog.push_back({op_special, rs, rt, rd, 5'd0, fn});
    endtask

    task automatic emit_halt();
        emit_r(5'd0, 5'd0, 5'd0, fn_jr);
        prog.push_back(32'd0); // Delay slot.
    endtask

    // Instruction-level model of the program. Returns the final v0.
    function automatic logic [31:0] iss_run();
        logic [31:0] mem [256];
        logic [31:0] gpr [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0] dst;
        logic armed;
        logic last;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i >= 1 && i <= prog.size()) ? prog[i - 1] : 32'd0;
        end
        for (int i = 0; i < 32; i++) begin
            gpr[i] = 32'd0;
        end
        pc = 32'd4;
        npc = 32'd8;
        armed = 1'b0;
        for (int step = 0; step < 4000; step++) begin
            ir = mem[pc[9:2]];
            pc = npc; // Now the delay-slot address.
            npc = npc + 32'd4;
            last = armed;
            a = gpr[ir[25:21]];
            b = gpr[ir[20:16]];
            simm = {{16{ir[15]}}, ir[15:0]};
            addr = a + simm;
            dst = ir[20:16];
            res = 32'd0;
            case (ir[31:26])
                op_special: begin
                    dst = ir[15:11];
                    case (ir[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_xor:  res = a ^ b;
                        fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
                        fn_jr: begin
                            npc = a;
                            armed = armed | (a == 32'd0);
                            dst = 5'd0;
                        end
                        default: dst = 5'd0;
                    endcase
                end
                op_addiu: res = a + simm;
                op_andi:  res = a & {16'h0000, ir[15:0]};
                op_ori:   res = a | {16'h0000, ir[15:0]};
                op_lui:   res = {ir[15:0], 16'h0000};
                op_lw:    res = mem[addr[9:2]];
                op_sw: begin
                    mem[addr[9:2]] = b;
                    dst = 5'd0;
                end
                default: begin
                    dst = 5'd0;
                    if ((ir[31:26] == op_beq && a == b) || (ir[31:26] == op_bne && a != b) ||
                        (ir[31:26] == op_bgtz && $signed(a) > 0) ||
                        (ir[31:26] == op_blez && $signed(a) <= 0)) begin
                        npc = pc + {simm[29:0], 2'b00};
                    end
                end
            endcase
            if (dst != 5'd0) begin
                gpr[dst] = res;
            end
            if (last) begin
                break;
            end
        end
        return gpr[2];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Compare v0 against the model on each halt.
    always @(negedge clk) begin
        if (was_active && !active && !rst) begin
            if (expected_q.size() == 0) begin
                $display("The processor halted with no program pending.");
                errors++;
            end else begin
                check_value("register_v0", expected_q.pop_front(), register_v0);
            end
            halts_seen++;
        end
        was_active = active;
    end

    // Hold reset, preload one word per cycle, then release.
    task automatic load_program();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            inst_input <= 1'b1;
            inst_addr <= 8'(4 * (i + 1));
            instruction <= prog[i];
        end
        @(posedge clk);
        inst_input <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_program(input string name);
        int target;
        int cycles;
        logic [31:0] expected;
        expected = iss_run();
        load_program();
        target = halts_seen + 1;
        expected_q.push_back(expected);
        @(negedge clk);
        if (active !== 1'b0) begin
            $display("After reset for the %s program, active was not low.", name);
            errors++;
        end
        cycles = 0;
        while (halts_seen != target && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (halts_seen != target) begin
            $display("The %s program timed out: active did not fall in 5000 cycles.", name);
            errors++;
            expected_q.delete();
        end
    endtask

    task automatic build_random();
        logic [31:0] r;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        prog.delete();
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            rs = {2'b00, r[18:16]};
            rt = {2'b00, r[21:19]};
            rd = {2'b00, r[24:22]};
            case (r[31:28] % 4'd10)
                4'd0: emit_i(op_addiu, rs, rt, r[15:0]);
                4'd1: emit_i(op_andi, rs, rt, r[15:0]);
                4'd2: emit_i(op_ori, rs, rt, r[15:0]);
                4'd3: emit_i(op_lui, 5'd0, rt, r[15:0]);
                4'd4: emit_r(rs, rt, rd, fn_addu);
                4'd5: emit_r(rs, rt, rd, fn_subu);
                4'd6: emit_r(rs, rt, rd, fn_and);
                4'd7: emit_r(rs, rt, rd, fn_or);
                4'd8: emit_r(rs, rt, rd, fn_xor);
                default: emit_r(rs, rt, rd, fn_sltu);
            endcase
        end
        emit_r(5'd2, 5'd3, 5'd2, fn_xor); // Fold other registers into v0.
        emit_r(5'd2, 5'd4, 5'd2, fn_addu);
        emit_halt();
    endtask

    initial begin
        rst = 1'b1;
        inst_input = 1'b0;
        inst_addr = 8'd0;
        instruction = 32'd0;

        prog.delete();
        emit_i(op_addiu, 5'd0, 5'd3, 16'h1234);
        emit_i(op_ori, 5'd0, 5'd4, 16'hf0f0);
        emit_i(op_lui, 5'd0, 5'd5, 16'h8001);
        emit_r(5'd3, 5'd4, 5'd2, fn_addu);
        emit_r(5'd2, 5'd5, 5'd2, fn_subu);
        emit_i(op_andi, 5'd2, 5'd6, 16'hff0f);
        emit_r(5'd2, 5'd6, 5'd2, fn_or);
        emit_r(5'd2, 5'd3, 5'd2, fn_xor);
        emit_r(5'd3, 5'd5, 5'd7, fn_sltu);
        emit_r(5'd2, 5'd7, 5'd2, fn_addu);
        emit_r(5'd2, 5'd4, 5'd8, fn_and);
        emit_r(5'd2, 5'd8, 5'd2, fn_addu);
        emit_halt();
        run_program("arithmetic");

        prog.delete();
        emit_i(op_addiu, 5'd0, 5'd3, 16'd3);
        emit_i(op_bgtz, 5'd3, 5'd0, 16'd2);    // Taken forward.
        emit_i(op_addiu, 5'd2, 5'd2, 16'd1);   // Delay slot.
        emit_i(op_addiu, 5'd2, 5'd2, 16'd100); // Skipped.
        emit_i(op_addiu, 5'd2, 5'd2, 16'd10);
        emit_i(op_addiu, 5'd3, 5'd3, 16'hffff);
        emit_i(op_bgtz, 5'd3, 5'd0, 16'hfffd); // Loop back three words.
        emit_i(op_addiu, 5'd2, 5'd2, 16'd1000);
        emit_i(op_blez, 5'd2, 5'd0, 16'd2);    // Not taken.
        emit_i(op_addiu, 5'd2, 5'd2, 16'd5);
        emit_i(op_addiu, 5'd2, 5'd2, 16'd7);
        emit_halt();
        run_program("bgtz loop");

        prog.delete();
        emit_i(op_lui, 5'd0, 5'd3, 16'h1234);
        emit_i(op_ori, 5'd3, 5'd3, 16'h5678);
        emit_i(op_lui, 5'd0, 5'd4, 16'h1234);
        emit_i(op_ori, 5'd4, 5'd4, 16'h5678);
        emit_i(op_beq, 5'd3, 5'd4, 16'd2);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0001);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0040);
        emit_i(op_bne, 5'd3, 5'd4, 16'd2);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0002);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0080);
        emit_i(op_bne, 5'd3, 5'd0, 16'd2);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0004);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0100);
        emit_i(op_beq, 5'd3, 5'd0, 16'd2);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0008);
        emit_i(op_addiu, 5'd2, 5'd2, 16'h0200);
        emit_halt();
        run_program("beq bne");

        prog.delete();
        emit_i(op_lui, 5'd0, 5'd3, 16'hcafe);
        emit_i(op_ori, 5'd3, 5'd3, 16'hbabe);
        emit_i(op_addiu, 5'd0, 5'd4, 16'h0100); // Data area above the program.
        emit_i(op_sw, 5'd4, 5'd3, 16'h0008);
        emit_i(op_lw, 5'd4, 5'd2, 16'h0008);
        emit_halt();
        run_program("load store");

        for (int n = 0; n < 20; n++) begin
            build_random();
            run_program("random");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker (
    input logic clk,
    input logic rst,
    input logic [31:0] address,
    input logic read,
    input logic write,
    input logic [avalon_pkg::data_width-1:0] writedata,
    input logic [3:0] byteenable,
    input logic waitrequest,
    input logic active
);
    import avalon_pkg::*;

    a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else $error("read and write asserted together");

    // A stalled transfer must not change.
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else $error("bus transfer changed while waitrequest was high");

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        (read || write) |-> address[1:0] == 2'b00)
        else $error("unaligned bus address");

    a_full_word: assert property (@(posedge clk) disable iff (rst)
        write |-> byteenable == be_full)
        else $error("partial byteenable on a write");

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !active |-> !read && !write)
        else $error("bus strobe while the processor is inactive");

endmodule

bind cpu_system cpu_checker u_checker (
    .clk(clk), .rst(rst), .address(address), .read(read), .write(write),
    .writedata(writedata), .byteenable(byteenable), .waitrequest(waitrequest),
    .active(active)
);

// ==== rtl/cpu_system.sv ====
`timescale 1ns/1ps

module cpu_system #(
    parameter logic [31:0] reset_pc = 32'd4,
    parameter int unsigned ram_words = 256,
    parameter int unsigned wait_states = avalon_pkg::default_wait_states
) (
    input  logic clk,
    input  logic rst,
    input  logic inst_input,
    input  logic [7:0] inst_addr,
    input  logic [31:0] instruction,
    output logic active,
    output logic [31:0] register_v0
);
    import mips_isa_pkg::*;
    import avalon_pkg::*;

    // Avalon bus between the CPU and the RAM.
    logic [31:0] address;
    logic read;
    logic write;
    logic [data_width-1:0] writedata;
    logic [3:0] byteenable;
    logic [data_width-1:0] readdata;
    logic waitrequest;

    logic [31:0] pc;
    logic pc_advance;
    logic pc_branch;
    logic pc_jump;
    logic [4:0] rs_addr;
    logic [4:0] rt_addr;
    logic [4:0] rd_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic reg_we;
    logic [31:0] reg_wdata;
    alu_op_t alu_op;
    logic alu_b_imm;
    logic [31:0] imm;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [5:0] branch_code;
    logic branch_taken;

    assign alu_b = alu_b_imm ? imm : rt_data; // Immediate or rt operand.

    cpu_control #(.reset_pc(reset_pc)) u_control (
        .clk, .rst, .pc, .alu_result, .branch_taken, .rs_data, .rt_data,
        .readdata, .waitrequest, .address, .read, .write, .writedata, .byteenable,
        .active, .pc_advance, .pc_branch, .pc_jump, .rs_addr, .rt_addr, .rd_addr,
        .reg_we, .reg_wdata, .alu_op, .alu_b_imm, .imm, .branch_code
    );

    pc_unit #(.reset_pc(reset_pc)) u_pc (
        .clk, .rst, .advance(pc_advance), .branch(pc_branch), .jump(pc_jump),
        .imm, .jump_target(rs_data), .pc
    );

    reg_file u_regs (
        .clk, .rst, .we(reg_we), .waddr(rd_addr), .raddr_a(rs_addr), .raddr_b(rt_addr),
        .wdata(reg_wdata), .rdata_a(rs_data), .rdata_b(rt_data), .v0(register_v0)
    );

    alu u_alu (
        .op(alu_op), .a(rs_data), .b(alu_b), .branch_code, .result(alu_result),
        .branch_taken
    );

    avalon_ram #(.ram_words(ram_words), .wait_states(wait_states)) u_ram (
        .clk, .rst, .address, .read, .write, .writedata, .byteenable, .waitrequest,
        .readdata, .inst_input, .inst_addr, .instruction
    );

endmodule

// ==== rtl/avalon_ram.sv ====
`timescale 1ns/1ps

module avalon_ram #(
    parameter int unsigned ram_words = 256,
    parameter int unsigned wait_states = avalon_pkg::default_wait_states
) (
    input  logic clk,
    input  logic rst,
    input  logic [31:0] address,
    input  logic read,
    input  logic write,
    input  logic [avalon_pkg::data_width-1:0] writedata,
    input  logic [3:0] byteenable,
    output logic waitrequest,
    output logic [avalon_pkg::data_width-1:0] readdata,
    input  logic inst_input,
    input  logic [7:0] inst_addr,
    input  logic [31:0] instruction
);
    import avalon_pkg::*;

    localparam int unsigned aw = $clog2(ram_words);
    localparam logic [1:0] ws = 2'(wait_states);

    logic [data_width-1:0] mem [ram_words];
    logic [aw-1:0] word_idx;
    logic [aw-1:0] preload_idx;
    logic [1:0] wait_cnt; // Wait cycles spent on the current read.

    assign word_idx = address[aw+1:2];
    assign preload_idx = aw'(inst_addr[7:2]);
    assign waitrequest = read && (wait_cnt != ws);
    assign readdata = mem[word_idx];

    always_ff @(posedge clk) begin
        if (rst || !waitrequest) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_input) begin
            mem[preload_idx] <= instruction;
        end else if (write) begin
            for (int i = 0; i < data_width / 8; i++) begin
                if (byteenable[i]) begin
                    mem[word_idx][8*i +: 8] <= writedata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== rtl/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control #(
    parameter logic [31:0] reset_pc = 32'd4
) (
    input  logic clk,
    input  logic rst,
    input  logic [31:0] pc,
    input  logic [31:0] alu_result,
    input  logic branch_taken,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    input  logic [avalon_pkg::data_width-1:0] readdata,
    input  logic waitrequest,
    output logic [31:0] address,
    output logic read,
    output logic write,
    output logic [avalon_pkg::data_width-1:0] writedata,
    output logic [3:0] byteenable,
    output logic active,
    output logic pc_advance,
    output logic pc_branch,
    output logic pc_jump,
    output logic [4:0] rs_addr,
    output logic [4:0] rt_addr,
    output logic [4:0] rd_addr,
    output logic reg_we,
    output logic [31:0] reg_wdata,
    output mips_isa_pkg::alu_op_t alu_op,
    output logic alu_b_imm,
    output logic [31:0] imm,
    output logic [5:0] branch_code
);
    import mips_isa_pkg::*;
    import avalon_pkg::*;

    typedef enum logic [2:0] {
        st_start, st_fetch, st_decode, st_execute, st_memory, st_writeback, st_idle
    } state_t;

    state_t state;
    state_t retire_state;
    logic [31:0] ir;
    logic [31:0] mdr; // Load data.
    logic halt_armed;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jr;
    logic writes_reg;

    assign opcode = ir[31:26];
    assign funct = ir[5:0];
    assign rs_addr = ir[25:21];
    assign rt_addr = ir[20:16];
    assign branch_code = opcode;

    assign is_load = opcode == op_lw;
    assign is_store = opcode == op_sw;
    assign is_branch = opcode inside {op_beq, op_bne, op_bgtz, op_blez};
    assign is_jr = (opcode == op_special) && (funct == fn_jr);

    always_comb begin
        alu_op = alu_add;
        alu_b_imm = 1'b1;
        writes_reg = 1'b0;
        rd_addr = ir[20:16];
        imm = {{16{ir[15]}}, ir[15:0]};
        case (opcode)
            op_special: begin
                alu_b_imm = 1'b0;
                rd_addr = ir[15:11];
                writes_reg = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_sltu: alu_op = alu_sltu;
                    default: writes_reg = 1'b0; // JR, NOP and unknown codes.
                endcase
            end
            op_addiu: writes_reg = 1'b1;
            op_andi: begin
                alu_op = alu_and;
                imm = {16'h0000, ir[15:0]}; // Logic immediates are zero extended.
                writes_reg = 1'b1;
            end
            op_ori: begin
                alu_op = alu_or;
                imm = {16'h0000, ir[15:0]};
                writes_reg = 1'b1;
            end
            op_lui: begin
                alu_op = alu_lui;
                writes_reg = 1'b1;
            end
            op_lw: writes_reg = 1'b1;
            op_beq, op_bne, op_bgtz, op_blez: alu_b_imm = 1'b0;
            default: ;
        endcase
    end

    // Bus master.
    assign read = (state == st_fetch) || ((state == st_memory) && is_load);
    assign write = (state == st_memory) && is_store;
    assign address = (state == st_memory) ? alu_result : pc;
    assign writedata = rt_data;
    assign byteenable = be_full;

    assign active = (state != st_start) && (state != st_idle);
    assign pc_advance = (state == st_fetch) && !waitrequest;
    assign pc_branch = (state == st_execute) && is_branch && branch_taken;
    assign pc_jump = (state == st_execute) && is_jr;
    assign reg_we = state == st_writeback;
    assign reg_wdata = is_load ? mdr : alu_result;

    // The delay slot after a halting JR is the last instruction.
    assign retire_state = halt_armed ? st_idle : st_fetch;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_start;
            halt_armed <= 1'b0;
        end else begin
            case (state)
                st_start: state <= st_fetch;
                st_fetch: begin
                    if (!waitrequest) begin
                        state <= st_decode;
                    end
                end
                st_decode: state <= st_execute;
                st_execute: begin
                    if (is_jr && (rs_data == 32'd0)) begin
                        halt_armed <= 1'b1;
                    end
                    if (is_load || is_store) begin
                        state <= st_memory;
                    end else if (writes_reg) begin
                        state <= st_writeback;
                    end else begin
                        state <= retire_state;
                    end
                end
                st_memory: begin
                    if (!waitrequest) begin
                        state <= is_load ? st_writeback : retire_state;
                    end
                end
                st_writeback: state <= retire_state;
                default: state <= st_idle; // Halted until the next reset.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_fetch) && !waitrequest) begin
            ir <= readdata;
        end
        if ((state == st_memory) && is_load && !waitrequest) begin
            mdr <= readdata;
        end
    end

endmodule

// ==== rtl/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [31:0] reset_pc = 32'd4
) (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic branch,
    input  logic jump,
    input  logic [31:0] imm,
    input  logic [31:0] jump_target,
    output logic [31:0] pc
);

    // Address of the instruction after pc. A taken branch or jump rewrites
    // it while pc still points at the delay slot.
    logic [31:0] next_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
            next_pc <= reset_pc + 32'd4;
        end else if (advance) begin
            pc <= next_pc; // Fetch done.
            next_pc <= next_pc + 32'd4;
        end else if (jump) begin
            next_pc <= jump_target;
        end else if (branch) begin
            next_pc <= pc + {imm[29:0], 2'b00}; // Offset is in words.
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic clk,
    input  logic rst,
    input  logic we,
    input  logic [4:0] waddr,
    input  logic [4:0] raddr_a,
    input  logic [4:0] raddr_b,
    input  logic [31:0] wdata,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    output logic [31:0] v0
);
    import mips_isa_pkg::*;

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata; // Register zero is never written.
        end
    end

    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];
    assign v0 = regs[reg_v0];

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  mips_isa_pkg::alu_op_t op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [5:0] branch_code,
    output logic [31:0] result,
    output logic branch_taken
);
    import mips_isa_pkg::*;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sltu: result = {31'd0, a < b}; // Unsigned compare.
            alu_lui:  result = {b[15:0], 16'h0000};
            default:  result = a + b;
        endcase
    end

    // BGTZ and BLEZ test rs against zero, signed.
    always_comb begin
        case (branch_code)
            op_beq:  branch_taken = a == b;
            op_bne:  branch_taken = a != b;
            op_bgtz: branch_taken = $signed(a) > 32'sd0;
            op_blez: branch_taken = $signed(a) <= 32'sd0;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/avalon_pkg.sv ====
package avalon_pkg;

    // Word width of the memory-mapped bus.
    localparam int unsigned data_width = 32;

    // Only whole-word transfers are issued.
    localparam logic [3:0] be_full = 4'b1111;

    // Read latency of the RAM slave when not overridden.
    localparam int unsigned default_wait_states = 1;

endpackage

// ==== rtl/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // Primary opcodes, instruction bits 31:26.
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // Funct field of SPECIAL instructions.
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam logic [4:0] reg_v0 = 5'd2; // Result register.

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sltu,
        alu_lui
    } alu_op_t;

endpackage
